/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    // instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes, inst[6:0]
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;

    localparam inst_t ebreak_word = 32'h0010_0073; // only system word accepted

    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt  = 7'b0100000; // sub, sra, srai

    // a0 receives the exit code on a stop
    localparam reg_idx_t stop_rd = 5'd10;

    // one value per recognised instruction
    typedef enum logic [5:0] {
        // register-register
        k_add, k_sub, k_sll, k_slt, k_sltu,
        k_xor, k_srl, k_sra, k_or, k_and,
        // loads and stores
        k_lb, k_lh, k_lw, k_lbu, k_lhu,
        k_sb, k_sh, k_sw,
        // branches
        k_beq, k_bne, k_blt, k_bge, k_bltu, k_bgeu,
        // upper immediates and jumps
        k_lui, k_auipc, k_jal, k_jalr,
        // register-immediate
        k_addi, k_slti, k_sltiu, k_xori, k_andi,
        k_slli, k_srli, k_srai, k_ori,
        k_ebreak,
        k_unknown
    } inst_kind_t;

endpackage

/* design/decode_ctrl_pkg.sv */
package decode_ctrl_pkg;

    typedef logic [2:0] alu_op_t;
    typedef logic [2:0] wb_src_t;
    typedef logic [1:0] cmp_type_t;
    typedef logic [7:0] wmask_t;

    // ALU operation codes
    localparam alu_op_t alu_add = 3'd0;
    localparam alu_op_t alu_sub = 3'd1; // also used by the set-less-than kinds
    localparam alu_op_t alu_sra = 3'd2;
    localparam alu_op_t alu_and = 3'd3;
    localparam alu_op_t alu_or  = 3'd4;
    localparam alu_op_t alu_xor = 3'd5;
    localparam alu_op_t alu_sll = 3'd6;
    localparam alu_op_t alu_srl = 3'd7;

    // source of the rd write data
    localparam wb_src_t wb_alu  = 3'd0;
    localparam wb_src_t wb_mem  = 3'd1;
    localparam wb_src_t wb_snpc = 3'd2; // pc + 4
    localparam wb_src_t wb_cmp  = 3'd3;
    localparam wb_src_t wb_none = 3'd4; // no register write

    // compare unit mode
    localparam cmp_type_t cmp_eq  = 2'd0;
    localparam cmp_type_t cmp_ne  = 2'd1;
    localparam cmp_type_t cmp_lt  = 2'd2;
    localparam cmp_type_t cmp_ltu = 2'd3;

    // byte enables, one bit per byte lane
    localparam wmask_t mask_word = 8'b0000_1111;
    localparam wmask_t mask_half = 8'b0000_0011;
    localparam wmask_t mask_byte = 8'b0000_0001;
    localparam wmask_t mask_none = 8'b0000_0000;

endpackage

/* design/inst_classify.sv */
`timescale 1ns/10ps

module inst_classify (
    input  rv_isa_pkg::inst_t      inst,
    output rv_isa_pkg::inst_kind_t kind
);
    import rv_isa_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        kind = k_unknown; // anything not matched below
        case (opcode)
            op_lui:   kind = k_lui;
            op_auipc: kind = k_auipc;
            op_jal:   kind = k_jal;
            op_jalr: begin
                if (funct3 == 3'b000) kind = k_jalr;
            end
            op_branch: begin
                case (funct3)
                    3'b000:  kind = k_beq;
                    3'b001:  kind = k_bne;
                    3'b100:  kind = k_blt;
                    3'b101:  kind = k_bge;
                    3'b110:  kind = k_bltu;
                    3'b111:  kind = k_bgeu;
                    default: kind = k_unknown;
                endcase
            end
            op_load: begin
                case (funct3)
                    3'b000:  kind = k_lb;
                    3'b001:  kind = k_lh;
                    3'b010:  kind = k_lw;
                    3'b100:  kind = k_lbu;
                    3'b101:  kind = k_lhu;
                    default: kind = k_unknown;
                endcase
            end
            op_store: begin
                case (funct3)
                    3'b000:  kind = k_sb;
                    3'b001:  kind = k_sh;
                    3'b010:  kind = k_sw;
                    default: kind = k_unknown;
                endcase
            end
            op_imm: begin
                case (funct3)
                    3'b000: kind = k_addi;
                    3'b010: kind = k_slti;
                    3'b011: kind = k_sltiu;
                    3'b100: kind = k_xori;
                    3'b110: kind = k_ori;
                    3'b111: kind = k_andi;
                    3'b001: if (funct7 == f7_base) kind = k_slli; // shamt in 24:20
                    3'b101: begin
                        if (funct7 == f7_base)     kind = k_srli;
                        else if (funct7 == f7_alt) kind = k_srai;
                    end
                    default: kind = k_unknown;
                endcase
            end
            op_reg: begin
                // funct7 is checked on every R-type entry
                if (funct7 == f7_base) begin
                    case (funct3)
                        3'b000: kind = k_add;
                        3'b001: kind = k_sll;
                        3'b010: kind = k_slt;
                        3'b011: kind = k_sltu;
                        3'b100: kind = k_xor;
                        3'b101: kind = k_srl;
                        3'b110: kind = k_or;
                        3'b111: kind = k_and;
                    endcase
                end else if (funct7 == f7_alt) begin
                    if (funct3 == 3'b000)      kind = k_sub;
                    else if (funct3 == 3'b101) kind = k_sra;
                end
            end
            default: begin
                if (inst == ebreak_word) kind = k_ebreak;
            end
        endcase
    end

endmodule

/* design/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen (
    input  rv_isa_pkg::inst_t      inst,
    input  rv_isa_pkg::inst_kind_t kind,
    output rv_isa_pkg::word_t      imm
);
    import rv_isa_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // all formats sign-extend from inst[31]
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (kind)
            k_addi, k_slti, k_sltiu, k_xori, k_ori, k_andi,
            k_slli, k_srli, k_srai,
            k_lb, k_lh, k_lw, k_lbu, k_lhu,
            k_jalr:
                imm = imm_i;
            k_sb, k_sh, k_sw:
                imm = imm_s;
            k_beq, k_bne, k_blt, k_bge, k_bltu, k_bgeu:
                imm = imm_b;
            k_lui, k_auipc:
                imm = imm_u;
            k_jal:
                imm = imm_j;
            default:
                imm = '0; // R-type, ebreak, unknown
        endcase
    end

endmodule

/* design/ctrl_gen.sv */
`timescale 1ns/10ps

module ctrl_gen (
    input  rv_isa_pkg::inst_kind_t     kind,
    output decode_ctrl_pkg::alu_op_t   alu_op,
    output decode_ctrl_pkg::wb_src_t   wb_src,
    output decode_ctrl_pkg::cmp_type_t cmp_type,
    output logic                       alu_src1,   // 0 rs1, 1 pc
    output logic                       alu_src2,   // 0 rs2, 1 imm
    output logic                       jump,
    output logic                       branch,
    output logic                       mem_en,
    output logic                       mem_wen,
    output decode_ctrl_pkg::wmask_t    mem_wmask,
    output logic                       stop_sim
);
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    logic is_branch;
    logic is_load;
    logic is_store;
    logic is_rtype;

    assign is_branch = kind inside {k_beq, k_bne, k_blt, k_bge, k_bltu, k_bgeu};
    assign is_load   = kind inside {k_lb, k_lh, k_lw, k_lbu, k_lhu};
    assign is_store  = kind inside {k_sb, k_sh, k_sw};
    assign is_rtype  = kind inside {k_add, k_sub, k_sll, k_slt, k_sltu,
                                    k_xor, k_srl, k_sra, k_or, k_and};

    always_comb begin
        case (kind)
            k_sub, k_slt, k_sltu, k_slti, k_sltiu: alu_op = alu_sub;
            k_sra, k_srai:                         alu_op = alu_sra;
            k_and, k_andi:                         alu_op = alu_and;
            k_or, k_ori:                           alu_op = alu_or;
            k_xor, k_xori:                         alu_op = alu_xor;
            k_sll, k_slli:                         alu_op = alu_sll;
            k_srl, k_srli:                         alu_op = alu_srl;
            default:                               alu_op = alu_add; // address and pc sums
        endcase
    end

    always_comb begin
        if (is_load)
            wb_src = wb_mem;
        else if (kind inside {k_jal, k_jalr})
            wb_src = wb_snpc;
        else if (kind inside {k_slt, k_sltu, k_slti, k_sltiu})
            wb_src = wb_cmp;
        else if (is_store || is_branch)
            wb_src = wb_none;
        else
            wb_src = wb_alu;
    end

    // branch conditions are resolved outside, from funct3
    always_comb begin
        case (kind)
            k_sltu, k_sltiu: cmp_type = cmp_ltu;
            k_slt, k_slti:   cmp_type = cmp_lt;
            default:         cmp_type = cmp_eq;
        endcase
    end

    assign alu_src1 = is_branch || (kind inside {k_auipc, k_jal}); // target = pc + imm
    assign alu_src2 = !is_rtype;

    assign jump   = kind inside {k_jal, k_jalr};
    assign branch = is_branch;

    assign mem_en  = is_load || is_store;
    assign mem_wen = is_store;

    always_comb begin
        case (kind)
            k_sw:    mem_wmask = mask_word;
            k_sh:    mem_wmask = mask_half;
            k_sb:    mem_wmask = mask_byte;
            default: mem_wmask = mask_none;
        endcase
    end

    assign stop_sim = kind inside {k_ebreak, k_unknown};

endmodule

/* design/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       inst_valid,
    input  rv_isa_pkg::inst_t          inst,
    output logic                       dec_valid,
    output rv_isa_pkg::reg_idx_t       rs1,
    output rv_isa_pkg::reg_idx_t       rs2,
    output rv_isa_pkg::reg_idx_t       rd,
    output rv_isa_pkg::word_t          imm,
    output decode_ctrl_pkg::alu_op_t   alu_op,
    output decode_ctrl_pkg::wb_src_t   wb_src,
    output decode_ctrl_pkg::cmp_type_t cmp_type,
    output logic                       alu_src1,
    output logic                       alu_src2,
    output logic                       jump,
    output logic                       branch,
    output logic                       mem_en,
    output logic                       mem_wen,
    output decode_ctrl_pkg::wmask_t    mem_wmask,
    output logic                       stop_sim
);
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    inst_kind_t kind;
    reg_idx_t   rs1_nxt;
    reg_idx_t   rd_nxt;
    word_t      imm_nxt;
    alu_op_t    alu_op_nxt;
    wb_src_t    wb_src_nxt;
    cmp_type_t  cmp_type_nxt;
    wmask_t     mem_wmask_nxt;
    logic       alu_src1_nxt;
    logic       alu_src2_nxt;
    logic       jump_nxt;
    logic       branch_nxt;
    logic       mem_en_nxt;
    logic       mem_wen_nxt;
    logic       stop_nxt;

    inst_classify u_inst_classify (
        .inst (inst),
        .kind (kind)
    );

    imm_gen u_imm_gen (
        .inst (inst),
        .kind (kind),
        .imm  (imm_nxt)
    );

    ctrl_gen u_ctrl_gen (
        .kind      (kind),
        .alu_op    (alu_op_nxt),
        .wb_src    (wb_src_nxt),
        .cmp_type  (cmp_type_nxt),
        .alu_src1  (alu_src1_nxt),
        .alu_src2  (alu_src2_nxt),
        .jump      (jump_nxt),
        .branch    (branch_nxt),
        .mem_en    (mem_en_nxt),
        .mem_wen   (mem_wen_nxt),
        .mem_wmask (mem_wmask_nxt),
        .stop_sim  (stop_nxt)
    );

    // lui reads x0 so the ALU sees 0 + imm
    assign rs1_nxt = (stop_nxt || kind == k_lui) ? reg_idx_t'(0) : inst[19:15];
    assign rd_nxt  = stop_nxt ? stop_rd : inst[11:7];

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            jump      <= 1'b0;
            branch    <= 1'b0;
            mem_en    <= 1'b0;
            mem_wen   <= 1'b0;
            stop_sim  <= 1'b0;
            mem_wmask <= mask_none;
            rs1       <= '0;
            rs2       <= '0;
            rd        <= '0;
            imm       <= '0;
            alu_op    <= alu_add;
            wb_src    <= wb_alu;
            cmp_type  <= cmp_eq;
            alu_src1  <= 1'b0;
            alu_src2  <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
            // strobes only live for a valid word
            jump      <= inst_valid && jump_nxt;
            branch    <= inst_valid && branch_nxt;
            mem_en    <= inst_valid && mem_en_nxt;
            mem_wen   <= inst_valid && mem_wen_nxt;
            stop_sim  <= inst_valid && stop_nxt;
            mem_wmask <= inst_valid ? mem_wmask_nxt : mask_none; // follows mem_wen
            if (inst_valid) begin
                rs1      <= rs1_nxt;
                rs2      <= inst[24:20];
                rd       <= rd_nxt;
                imm      <= imm_nxt;
                alu_op   <= alu_op_nxt;
                wb_src   <= wb_src_nxt;
                cmp_type <= cmp_type_nxt;
                alu_src1 <= alu_src1_nxt;
                alu_src2 <= alu_src2_nxt;
            end
        end
    end

endmodule

/* tests/decode_stage_properties.sv */
`timescale 1ns/10ps

module decode_stage_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    dec_valid,
    input logic                    jump,
    input logic                    branch,
    input logic                    mem_en,
    input logic                    mem_wen,
    input logic                    stop_sim,
    input decode_ctrl_pkg::wmask_t mem_wmask
);

    // no strobe without a valid word
    a_idle_strobes: assert property (@(posedge clk) disable iff (rst)
        !dec_valid |-> !(jump || branch || mem_en || mem_wen || stop_sim))
        else $error("strobe high while dec_valid is low");

    a_wen_needs_en: assert property (@(posedge clk) disable iff (rst) mem_wen |-> mem_en)
        else $error("mem_wen without mem_en");

    a_jump_or_branch: assert property (@(posedge clk) disable iff (rst) !(jump && branch))
        else $error("jump and branch both high");

    a_mask_with_wen: assert property (@(posedge clk) disable iff (rst)
        (mem_wmask != '0) == mem_wen)
        else $error("mem_wmask disagrees with mem_wen");

endmodule

bind decode_stage decode_stage_properties u_decode_stage_properties (
    .clk       (clk),
    .rst       (rst),
    .dec_valid (dec_valid),
    .jump      (jump),
    .branch    (branch),
    .mem_en    (mem_en),
    .mem_wen   (mem_wen),
    .stop_sim  (stop_sim),
    .mem_wmask (mem_wmask)
);

/* tests/decode_stage_tb.sv */
`timescale 1ns/10ps

module decode_stage_tb;
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    localparam int max_cycles = 2000;

    logic      clk;
    logic      rst;
    logic      inst_valid;
    inst_t     inst;
    logic      dec_valid;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     imm;
    alu_op_t   alu_op;
    wb_src_t   wb_src;
    cmp_type_t cmp_type;
    logic      alu_src1;
    logic      alu_src2;
    logic      jump;
    logic      branch;
    logic      mem_en;
    logic      mem_wen;
    wmask_t    mem_wmask;
    logic      stop_sim;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    string       cur = "reset";
    logic [15:0] lfsr;

    decode_stage u_decode_stage (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            errors++;
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("%0d checks run, %0d errors", checks, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[15]}; // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic word_t sext(input word_t v, input int bits);
        word_t m;
        m = word_t'(1) << (bits - 1);
        return (v ^ m) - m;
    endfunction

    // R-type words go through here too, with {funct7, rs2} in the imm slot
    function automatic inst_t enc_i(input logic [11:0] i12, input reg_idx_t s1,
                                    input logic [2:0] f3, input reg_idx_t d, input opcode_t op);
        return {i12, s1, f3, d, op};
    endfunction

    function automatic inst_t enc_s(input logic [11:0] i12, input reg_idx_t s2,
                                    input reg_idx_t s1, input logic [2:0] f3);
        return {i12[11:5], s2, s1, f3, i12[4:0], op_store};
    endfunction

    function automatic inst_t enc_b(input logic [12:0] i13, input reg_idx_t s2,
                                    input reg_idx_t s1, input logic [2:0] f3);
        return {i13[12], i13[10:5], s2, s1, f3, i13[4:1], i13[11], op_branch};
    endfunction

    function automatic inst_t enc_u(input logic [19:0] i20, input reg_idx_t d, input opcode_t op);
        return {i20, d, op};
    endfunction

    function automatic inst_t enc_j(input logic [20:0] i21, input reg_idx_t d);
        return {i21[20], i21[10:1], i21[11], i21[19:12], d, op_jal};
    endfunction

    task automatic mismatch(input string nm, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("Fail at %0t: %s %s is %h, expected %h", $time, cur, nm, got, exp);
    endtask

    task automatic check_word(input string nm, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) mismatch(nm, got, exp);
    endtask

    task automatic check_reg(input string nm, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) mismatch(nm, got, exp);
    endtask

    task automatic check_alu_op(input string nm, input alu_op_t got, input alu_op_t exp);
        checks++;
        if (got !== exp) mismatch(nm, got, exp);
    endtask

    task automatic check_wb_src(input string nm, input wb_src_t got, input wb_src_t exp);
        checks++;
        if (got !== exp) mismatch(nm, got, exp);
    endtask

    task automatic check_cmp(input string nm, input cmp_type_t got, input cmp_type_t exp);
        checks++;
        if (got !== exp) mismatch(nm, got, exp);
    endtask

    task automatic check_mask(input string nm, input wmask_t got, input wmask_t exp);
        checks++;
        if (got !== exp) mismatch(nm, got, exp);
    endtask

    task automatic check_bit(input string nm, input logic got, input logic exp);
        checks++;
        if (got !== exp) mismatch(nm, got, exp);
    endtask

    // drive 1 ns after the edge, return 1 ns after the edge that loads the word
    task automatic apply(input inst_t w, input logic v);
        inst = w;
        inst_valid = v;
        @(posedge clk);
        #1;
    endtask

    task automatic check_all(input reg_idx_t e_rs1, e_rs2, e_rd, input word_t e_imm,
                             input alu_op_t e_op, input wb_src_t e_wb, input cmp_type_t e_ct,
                             input logic e_src1, e_src2, e_jump, e_branch, e_men, e_mwen,
                             input wmask_t e_mask, input logic e_stop);
        check_bit("dec_valid", dec_valid, 1'b1);
        check_reg("rs1", rs1, e_rs1);
        check_reg("rs2", rs2, e_rs2);
        check_reg("rd", rd, e_rd);
        check_word("imm", imm, e_imm);
        check_alu_op("alu_op", alu_op, e_op);
        check_wb_src("wb_src", wb_src, e_wb);
        check_cmp("cmp_type", cmp_type, e_ct);
        check_bit("alu_src1", alu_src1, e_src1);
        check_bit("alu_src2", alu_src2, e_src2);
        check_bit("jump", jump, e_jump);
        check_bit("branch", branch, e_branch);
        check_bit("mem_en", mem_en, e_men);
        check_bit("mem_wen", mem_wen, e_mwen);
        check_mask("mem_wmask", mem_wmask, e_mask);
        check_bit("stop_sim", stop_sim, e_stop);
    endtask

    task automatic check_idle();
        check_bit("dec_valid", dec_valid, 1'b0);
        check_bit("jump", jump, 1'b0);
        check_bit("branch", branch, 1'b0);
        check_bit("mem_en", mem_en, 1'b0);
        check_bit("mem_wen", mem_wen, 1'b0);
        check_bit("stop_sim", stop_sim, 1'b0);
    endtask

    // each word would raise a different strobe if it were valid
    task automatic idle_case(input string nm, input inst_t w);
        cur = nm;
        apply(w, 1'b0);
        check_idle();
        check_reg("rd", rd, 5'd0); // data fields hold their reset value
        check_word("imm", imm, 32'd0);
    endtask

    task automatic reset_and_idle();
        cur = "reset";
        check_idle();
        check_word("imm", imm, 32'd0);
        idle_case("invalid sw", enc_s(12'h7ff, 5'd2, 5'd1, 3'd2));
        idle_case("invalid jal", enc_j(21'h000800, 5'd1));
        idle_case("invalid beq", enc_b(13'h0010, 5'd2, 5'd1, 3'd0));
        idle_case("invalid ebreak", ebreak_word);
    endtask

    task automatic alu_case(input string nm, input logic use_imm, input logic [2:0] f3,
                            input logic [11:0] i12, input alu_op_t op, input wb_src_t wb,
                            input cmp_type_t ct);
        cur = nm;
        apply(enc_i(i12, 5'd6, f3, 5'd12, use_imm ? op_imm : op_reg), 1'b1);
        check_all(5'd6, i12[4:0], 5'd12, use_imm ? sext(i12, 12) : 32'd0, op, wb, ct,
                  1'b0, use_imm, 1'b0, 1'b0, 1'b0, 1'b0, mask_none, 1'b0);
    endtask

    task automatic alu_kinds();
        alu_case("add", 1'b0, 3'd0, {f7_base, 5'd7}, alu_add, wb_alu, cmp_eq);
        alu_case("sub", 1'b0, 3'd0, {f7_alt, 5'd7}, alu_sub, wb_alu, cmp_eq);
        alu_case("sll", 1'b0, 3'd1, {f7_base, 5'd7}, alu_sll, wb_alu, cmp_eq);
        alu_case("slt", 1'b0, 3'd2, {f7_base, 5'd7}, alu_sub, wb_cmp, cmp_lt);
        alu_case("sltu", 1'b0, 3'd3, {f7_base, 5'd7}, alu_sub, wb_cmp, cmp_ltu);
        alu_case("xor", 1'b0, 3'd4, {f7_base, 5'd7}, alu_xor, wb_alu, cmp_eq);
        alu_case("srl", 1'b0, 3'd5, {f7_base, 5'd7}, alu_srl, wb_alu, cmp_eq);
        alu_case("sra", 1'b0, 3'd5, {f7_alt, 5'd7}, alu_sra, wb_alu, cmp_eq);
        alu_case("or", 1'b0, 3'd6, {f7_base, 5'd7}, alu_or, wb_alu, cmp_eq);
        alu_case("and", 1'b0, 3'd7, {f7_base, 5'd7}, alu_and, wb_alu, cmp_eq);
        alu_case("addi", 1'b1, 3'd0, 12'hffb, alu_add, wb_alu, cmp_eq); // -5
        alu_case("slti", 1'b1, 3'd2, 12'h064, alu_sub, wb_cmp, cmp_lt);
        alu_case("sltiu", 1'b1, 3'd3, 12'h800, alu_sub, wb_cmp, cmp_ltu);
        alu_case("xori", 1'b1, 3'd4, 12'hfff, alu_xor, wb_alu, cmp_eq);
        alu_case("ori", 1'b1, 3'd6, 12'h5a5, alu_or, wb_alu, cmp_eq);
        alu_case("andi", 1'b1, 3'd7, 12'h0f0, alu_and, wb_alu, cmp_eq);
        alu_case("slli", 1'b1, 3'd1, {f7_base, 5'd7}, alu_sll, wb_alu, cmp_eq);
        alu_case("srli", 1'b1, 3'd5, {f7_base, 5'd9}, alu_srl, wb_alu, cmp_eq);
        alu_case("srai", 1'b1, 3'd5, {f7_alt, 5'd9}, alu_sra, wb_alu, cmp_eq);
    endtask

    task automatic mem_case(input string nm, input logic store, input logic [2:0] f3,
                            input wmask_t mask);
        logic [11:0] ofs;
        cur = nm;
        ofs = store ? 12'h9a4 : 12'h7f8;
        if (store)
            apply(enc_s(ofs, 5'd8, 5'd5, f3), 1'b1);
        else
            apply(enc_i(ofs, 5'd5, f3, 5'd9, op_load), 1'b1);
        check_all(5'd5, store ? 5'd8 : ofs[4:0], store ? ofs[4:0] : 5'd9, sext(ofs, 12),
                  alu_add, store ? wb_none : wb_mem, cmp_eq, 1'b0, 1'b1, 1'b0, 1'b0,
                  1'b1, store, mask, 1'b0);
    endtask

    task automatic mem_kinds();
        mem_case("lb", 1'b0, 3'd0, mask_none);
        mem_case("lh", 1'b0, 3'd1, mask_none);
        mem_case("lw", 1'b0, 3'd2, mask_none);
        mem_case("lbu", 1'b0, 3'd4, mask_none);
        mem_case("lhu", 1'b0, 3'd5, mask_none);
        mem_case("sb", 1'b1, 3'd0, mask_byte);
        mem_case("sh", 1'b1, 3'd1, mask_half);
        mem_case("sw", 1'b1, 3'd2, mask_word);
    endtask

    task automatic branch_case(input string nm, input logic [2:0] f3);
        logic [12:0] ofs;
        cur = nm;
        ofs = 13'h1ff4; // -12
        apply(enc_b(ofs, 5'd11, 5'd4, f3), 1'b1);
        check_all(5'd4, 5'd11, {ofs[4:1], ofs[11]}, sext(ofs, 13), alu_add, wb_none, cmp_eq,
                  1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, mask_none, 1'b0);
    endtask

    task automatic flow_kinds();
        inst_t w;
        branch_case("beq", 3'd0);
        branch_case("bne", 3'd1);
        branch_case("blt", 3'd4);
        branch_case("bge", 3'd5);
        branch_case("bltu", 3'd6);
        branch_case("bgeu", 3'd7);
        cur = "jal";
        w = enc_j(21'h1ff80c, 5'd1);
        apply(w, 1'b1);
        check_all(w[19:15], w[24:20], 5'd1, sext(32'h1ff80c, 21), alu_add, wb_snpc, cmp_eq,
                  1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, mask_none, 1'b0);
        cur = "jalr";
        apply(enc_i(12'hff0, 5'd3, 3'd0, 5'd1, op_jalr), 1'b1);
        check_all(5'd3, 5'h10, 5'd1, 32'hffff_fff0, alu_add, wb_snpc, cmp_eq,
                  1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, mask_none, 1'b0);
        cur = "lui";
        w = enc_u(20'hfedcb, 5'd15, op_lui); // rs1 field is nonzero here
        apply(w, 1'b1);
        check_all(5'd0, w[24:20], 5'd15, 32'hfedc_b000, alu_add, wb_alu, cmp_eq,
                  1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, mask_none, 1'b0);
        cur = "auipc";
        w = enc_u(20'h12345, 5'd16, op_auipc);
        apply(w, 1'b1);
        check_all(w[19:15], w[24:20], 5'd16, 32'h1234_5000, alu_add, wb_alu, cmp_eq,
                  1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, mask_none, 1'b0);
    endtask

    task automatic stop_case(input string nm, input inst_t w);
        cur = nm;
        apply(w, 1'b1);
        check_all(5'd0, w[24:20], 5'd10, 32'd0, alu_add, wb_alu, cmp_eq,
                  1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, mask_none, 1'b1);
    endtask

    task automatic stop_kinds();
        stop_case("ebreak", 32'h0010_0073);
        stop_case("bad opcode", enc_i(12'h123, 5'd9, 3'd0, 5'd4, 7'b1111111));
        stop_case("add bad funct7", enc_i({7'b0000001, 5'd3}, 5'd9, 3'd0, 5'd4, op_reg));
    endtask

    // one word per cycle, each checked just before the next is driven
    task automatic random_stream();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        for (int i = 0; i < 8; i++) begin
            cur = "random add";
            draw(5, a);
            draw(5, b);
            draw(5, c);
            apply(enc_i({f7_base, c[4:0]}, b[4:0], 3'd0, a[4:0], op_reg), 1'b1);
            check_all(b[4:0], c[4:0], a[4:0], 32'd0, alu_add, wb_alu, cmp_eq,
                      1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, mask_none, 1'b0);
            cur = "random addi";
            draw(5, a);
            draw(5, b);
            draw(12, d);
            apply(enc_i(d[11:0], b[4:0], 3'd0, a[4:0], op_imm), 1'b1);
            check_all(b[4:0], d[4:0], a[4:0], sext(d[11:0], 12), alu_add, wb_alu, cmp_eq,
                      1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, mask_none, 1'b0);
            cur = "random sw";
            draw(5, b);
            draw(5, c);
            draw(12, d);
            apply(enc_s(d[11:0], c[4:0], b[4:0], 3'd2), 1'b1);
            check_all(b[4:0], c[4:0], d[4:0], sext(d[11:0], 12), alu_add, wb_none, cmp_eq,
                      1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, mask_word, 1'b0);
        end
    endtask

    initial begin
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        lfsr = 16'd74;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_and_idle();
        alu_kinds();
        mem_kinds();
        flow_kinds();
        stop_kinds();
        random_stream();
        $display("%0d checks run, %0d errors", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* rv_decode.f */
design/rv_isa_pkg.sv
design/decode_ctrl_pkg.sv
design/inst_classify.sv
design/imm_gen.sv
design/ctrl_gen.sv
design/decode_stage.sv
tests/decode_stage_properties.sv
tests/decode_stage_tb.sv

/* Bender.yml */
package:
  name: rv_decode

sources:
  - design/rv_isa_pkg.sv
  - design/decode_ctrl_pkg.sv
  - design/inst_classify.sv
  - design/imm_gen.sv
  - design/ctrl_gen.sv
  - design/decode_stage.sv
  - target: test
    files:
      - tests/decode_stage_properties.sv
      - tests/decode_stage_tb.sv
